/* eval_top.f */
eval_pkg.sv
board_latch.sv
rank_eval.sv
eval_blend.sv
eval_top.sv
eval_top_chk.sv
eval_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the eval_top testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module eval_top_tb -f eval_top.f -o sim_eval_top
./obj_dir/sim_eval_top | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
   exit 1
fi
exit 0

/* eval_top_tb.sv */
/* Directed testbench for eval_top with its own reference scorer
   Runs with EVAL_WIDTH 16 and TAG_WIDTH 8; fewer than 256 boards per run */
`default_nettype none

module eval_top_tb;

   localparam int          TIMEOUT = 200;  // Cycles allowed for any single wait
   localparam logic [31:0] SEED    = 32'hf18eed46;

   logic               clk = 1'b0;
   logic               arst_n;
   logic               in_valid;
   logic               in_ready;
   logic [255:0]       board;
   logic [7:0]         in_tag;
   logic               out_valid;
   logic               out_ready = 1'b1;
   logic signed [15:0] eval;
   logic [7:0]         out_tag;

   logic [31:0]        stim_lfsr    = SEED;
   logic [31:0]        ready_lfsr   = SEED;
   logic               toggle_ready = 1'b0;
   logic [7:0]         next_tag     = '0;
   logic [7:0]         exp_tag_q [$];   // Accepted tags in order
   logic signed [15:0] exp_eval [256];  // Expected score by tag
   string              test_name    = "reset";
   int                 checks       = 0;
   int                 value_errors = 0;
   int                 other_errors = 0;

   eval_top #(.EVAL_WIDTH(16), .TAG_WIDTH(8)) dut0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .board     (board),
      .in_tag    (in_tag),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .eval      (eval),
      .out_tag   (out_tag)
   );

   always #2 clk = ~clk;

   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
   endfunction

   // {mg, eg, phase} for one piece kind
   function automatic logic [31:0] piece_entry(input logic [2:0] kind);
      case (kind)
         3'd1:    return {12'd82, 12'd94, 8'd0};
         3'd2:    return {12'd337, 12'd281, 8'd3};
         3'd3:    return {12'd365, 12'd297, 8'd3};
         3'd4:    return {12'd477, 12'd512, 8'd5};
         3'd5:    return {12'd1025, 12'd936, 8'd9};
         default: return 32'd0;  // Empty, king and kind 7
      endcase
   endfunction

   function automatic logic signed [15:0] ref_eval(input logic [255:0] b);
      longint      mg;
      longint      eg;
      longint      ph;
      longint      scaled;
      logic [3:0]  code;
      logic [31:0] entry;
      mg = 0;
      eg = 0;
      ph = 0;
      for (int i = 0; i < 64; i++)
      begin
         code  = b[4*i +: 4];
         entry = piece_entry(code[2:0]);
         mg    = code[3] ? mg - entry[31:20] : mg + entry[31:20];
         eg    = code[3] ? eg - entry[19:8] : eg + entry[19:8];
         ph    = ph + entry[7:0];
      end
      if (ph > 62)
         ph = 62;
      scaled = ((mg * ph + eg * (62 - ph)) * 16912) / 1048576;  // Truncates toward zero
      return scaled[15:0];
   endfunction

   function automatic logic [255:0] place(input logic [255:0] b, input int sq,
                                          input logic [3:0] code);
      logic [255:0] r;
      r = b;
      r[4*sq +: 4] = code;
      return r;
   endfunction

   function automatic logic [255:0] start_board();
      logic [255:0] b;
      logic [3:0]   back [8];
      b    = '0;
      back = '{4'd4, 4'd2, 4'd3, 4'd5, 4'd6, 4'd3, 4'd2, 4'd4};
      for (int f = 0; f < 8; f++)
      begin
         b = place(b, f, back[f]);
         b = place(b, 8 + f, 4'd1);
         b = place(b, 48 + f, 4'd9);
         b = place(b, 56 + f, back[f] | 4'd8);  // Black copy of the back rank
      end
      return b;
   endfunction

   task automatic random_board(output logic [255:0] b);
      for (int i = 0; i < 256; i++)
      begin
         b[i]      = stim_lfsr[0];
         stim_lfsr = lfsr_step(stim_lfsr);
      end
   endtask

   // Called just after a rising edge; returns just after the accepting edge
   task automatic send_board(input logic [255:0] b, input logic signed [15:0] exp);
      int waited;
      waited   = 0;
      board    <= b;
      in_tag   <= next_tag;
      in_valid <= 1'b1;
      exp_eval[next_tag] = exp;
      @(negedge clk);
      while (!in_ready && waited < TIMEOUT)
      begin
         @(negedge clk);
         waited++;
      end
      assert (in_ready)
      else
      begin
         $display("Timeout in %s: in_ready stayed low", test_name);
         other_errors++;
      end
      if (in_ready)
         exp_tag_q.push_back(next_tag);
      @(posedge clk);
      next_tag++;
   endtask

   task automatic drain_results();
      int waited;
      waited   = 0;
      in_valid <= 1'b0;
      while (exp_tag_q.size() != 0 && waited < TIMEOUT)
      begin
         @(posedge clk);
         waited++;
      end
      assert (exp_tag_q.size() == 0)
      else
      begin
         $display("Timeout in %s: %0d results never came out",
                  test_name, exp_tag_q.size());
         other_errors++;
         exp_tag_q.delete();
      end
      @(posedge clk);
   endtask

   // Output side sampled at the falling edge before the handshake edge
   always @(negedge clk)
   begin : monitor
      logic [7:0] exp_tag;
      if (arst_n && out_valid && out_ready)
      begin
         assert (exp_tag_q.size() != 0)
         else
         begin
            $display("Result with tag %0d came out with no board pending", out_tag);
            other_errors++;
         end
         if (exp_tag_q.size() != 0)
         begin
            exp_tag = exp_tag_q.pop_front();
            checks++;
            assert (out_tag == exp_tag)
            else
            begin
               $display("ERROR %s: tag expected %0d, actual %0d", test_name, exp_tag, out_tag);
               value_errors++;
            end
            assert (eval == exp_eval[exp_tag])
            else
            begin
               $display("ERROR %s: tag %0d eval expected %0d, actual %0d",
                        test_name, exp_tag, exp_eval[exp_tag], eval);
               value_errors++;
            end
         end
      end
   end

   always @(posedge clk)
   begin
      if (toggle_ready)
      begin
         out_ready  <= ready_lfsr[0];
         ready_lfsr <= lfsr_step(ready_lfsr);
      end
      else
         out_ready <= 1'b1;
   end

   task automatic test_reset();
      @(negedge clk);
      checks++;
      assert (out_valid == 1'b0 && in_ready == 1'b1)
      else
      begin
         $display("ERROR reset: expected out_valid 0 in_ready 1, actual %0b %0b",
                  out_valid, in_ready);
         value_errors++;
      end
      @(posedge clk);
   endtask

   task automatic test_fixed();
      logic [255:0] kings;
      test_name = "fixed";
      kings     = place(place('0, 4, 4'd6), 60, 4'd14);
      send_board(start_board(), 16'sd0);
      send_board(place(kings, 3, 4'd5), 16'sd948);    // t = 58833 scaled by 16912 over 2^20
      send_board(place(kings, 59, 4'd13), -16'sd948);
      drain_results();
   endtask

   task automatic test_unused();
      logic [255:0] clean;
      logic [255:0] b;
      test_name = "unused";
      clean     = place(place(place('0, 4, 4'd6), 60, 4'd14), 0, 4'd4);
      b         = clean;
      for (int sq = 8; sq < 56; sq += 5)
         b = place(b, sq, (sq % 2 == 1) ? 4'hf : 4'h7);
      send_board(clean, ref_eval(clean));
      send_board(b, ref_eval(clean));
      drain_results();
   endtask

   task automatic test_phase();
      logic [255:0] pawns;
      logic [255:0] heavy;
      test_name = "phase";
      pawns     = '0;
      heavy     = '0;
      for (int f = 0; f < 8; f++)
         pawns = place(pawns, 8 + f, 4'd1);
      for (int f = 0; f < 3; f++)
         pawns = place(pawns, 48 + f, 4'd9);
      for (int f = 0; f < 4; f++)
      begin
         heavy = place(place(heavy, f, 4'd5), 4 + f, 4'd4);
         heavy = place(place(heavy, 56 + f, 4'd13), 60 + f, 4'd10);  // Phase 104
      end
      send_board(pawns, ref_eval(pawns));
      send_board(heavy, ref_eval(heavy));
      drain_results();
   endtask

   task automatic test_random(input string name, input logic stall);
      logic [255:0] b;
      test_name    = name;
      toggle_ready <= stall;
      repeat (40)
      begin
         random_board(b);
         send_board(b, ref_eval(b));
      end
      drain_results();
      toggle_ready <= 1'b0;
      repeat (2) @(posedge clk);
   endtask

   initial
   begin
      arst_n   = 1'b0;
      in_valid = 1'b0;
      board    = '0;
      in_tag   = '0;
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      test_reset();
      test_fixed();
      test_unused();
      test_phase();
      test_random("stream", 1'b0);
      test_random("backpressure", 1'b1);
      $display("Checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0 && checks > 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* eval_top_chk.sv */
/* Output handshake assertions, bound into every eval_top instance
   Checks are off while arst_n is low */
`default_nettype none

module eval_top_chk #(
   parameter int EVAL_WIDTH = 16,
   parameter int TAG_WIDTH  = 8
) (
   input logic                         clk,
   input logic                         arst_n,
   input logic                         in_ready,
   input logic                         out_valid,
   input logic                         out_ready,
   input logic signed [EVAL_WIDTH-1:0] eval,
   input logic [TAG_WIDTH-1:0]         out_tag
);

   // A held result stays put until it is taken
   a_hold: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(eval) && $stable(out_tag))
      else $error("Output changed while stalled");

   a_stall: assert property (@(posedge clk) disable iff (!arst_n)
      !in_ready |-> out_valid)
      else $error("in_ready low with no result waiting");

   a_known: assert property (@(posedge clk) disable iff (!arst_n)
      !$isunknown(out_valid))
      else $error("out_valid unknown");

endmodule

bind eval_top eval_top_chk #(
   .EVAL_WIDTH (EVAL_WIDTH),
   .TAG_WIDTH  (TAG_WIDTH)
) chk0 (
   .clk       (clk),
   .arst_n    (arst_n),
   .in_ready  (in_ready),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .eval      (eval),
   .out_tag   (out_tag)
);

`default_nettype wire

/* eval_top.sv */
/* Five-stage board scorer with valid/ready on both sides
   in_ready follows out_ready combinationally; eval wraps at EVAL_WIDTH bits */
`default_nettype none

module eval_top #(
   parameter int EVAL_WIDTH = 16,
   parameter int TAG_WIDTH  = 8
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          in_valid,
   output logic                          in_ready,
   input  logic [eval_pkg::BOARD_W-1:0]  board,
   input  logic [TAG_WIDTH-1:0]          in_tag,
   output logic                          out_valid,
   input  logic                          out_ready,
   output logic signed [EVAL_WIDTH-1:0]  eval,
   output logic [TAG_WIDTH-1:0]          out_tag
);

   logic [eval_pkg::BOARD_W-1:0] board_q;
   logic [TAG_WIDTH-1:0]         tag_q;
   logic                         board_valid_q;

   logic signed [EVAL_WIDTH-1:0] rank_mg [eval_pkg::RANKS];
   logic signed [EVAL_WIDTH-1:0] rank_eg [eval_pkg::RANKS];
   logic [eval_pkg::PHASE_W-1:0] rank_phase [eval_pkg::RANKS];

   board_latch #(
      .TAG_WIDTH (TAG_WIDTH)
   ) u_latch (
      .clk           (clk),
      .arst_n        (arst_n),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .board         (board),
      .in_tag        (in_tag),
      .board_q       (board_q),
      .tag_q         (tag_q),
      .board_valid_q (board_valid_q)
   );

   // One scorer per rank, all identical
   for (genvar r = 0; r < eval_pkg::RANKS; r++)
   begin : g_rank
      rank_eval #(
         .EVAL_WIDTH (EVAL_WIDTH)
      ) u_rank (
         .clk        (clk),
         .arst_n     (arst_n),
         .advance    (in_ready),
         .rank       (board_q[r*eval_pkg::RANK_W +: eval_pkg::RANK_W]),
         .rank_mg    (rank_mg[r]),
         .rank_eg    (rank_eg[r]),
         .rank_phase (rank_phase[r])
      );
   end

   eval_blend #(
      .EVAL_WIDTH (EVAL_WIDTH),
      .TAG_WIDTH  (TAG_WIDTH)
   ) u_blend (
      .clk           (clk),
      .arst_n        (arst_n),
      .board_valid_q (board_valid_q),
      .tag_q         (tag_q),
      .rank_mg_0     (rank_mg[0]),
      .rank_mg_1     (rank_mg[1]),
      .rank_mg_2     (rank_mg[2]),
      .rank_mg_3     (rank_mg[3]),
      .rank_mg_4     (rank_mg[4]),
      .rank_mg_5     (rank_mg[5]),
      .rank_mg_6     (rank_mg[6]),
      .rank_mg_7     (rank_mg[7]),
      .rank_eg_0     (rank_eg[0]),
      .rank_eg_1     (rank_eg[1]),
      .rank_eg_2     (rank_eg[2]),
      .rank_eg_3     (rank_eg[3]),
      .rank_eg_4     (rank_eg[4]),
      .rank_eg_5     (rank_eg[5]),
      .rank_eg_6     (rank_eg[6]),
      .rank_eg_7     (rank_eg[7]),
      .rank_phase_0  (rank_phase[0]),
      .rank_phase_1  (rank_phase[1]),
      .rank_phase_2  (rank_phase[2]),
      .rank_phase_3  (rank_phase[3]),
      .rank_phase_4  (rank_phase[4]),
      .rank_phase_5  (rank_phase[5]),
      .rank_phase_6  (rank_phase[6]),
      .rank_phase_7  (rank_phase[7]),
      .out_ready     (out_ready),
      .advance       (in_ready),   // Same stall drives every stage
      .out_valid     (out_valid),
      .eval          (eval),
      .out_tag       (out_tag)
   );

endmodule

`default_nettype wire

/* eval_blend.sv */
/* Rank sum, phase clamp and mg/eg blend over three stages; owns the stall
   eval keeps only the low EVAL_WIDTH bits of the blended score */
`default_nettype none

module eval_blend #(
   parameter int EVAL_WIDTH = 16,
   parameter int TAG_WIDTH  = 8
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          board_valid_q,
   input  logic [TAG_WIDTH-1:0]          tag_q,
   input  logic signed [EVAL_WIDTH-1:0]  rank_mg_0,
   input  logic signed [EVAL_WIDTH-1:0]  rank_mg_1,
   input  logic signed [EVAL_WIDTH-1:0]  rank_mg_2,
   input  logic signed [EVAL_WIDTH-1:0]  rank_mg_3,
   input  logic signed [EVAL_WIDTH-1:0]  rank_mg_4,
   input  logic signed [EVAL_WIDTH-1:0]  rank_mg_5,
   input  logic signed [EVAL_WIDTH-1:0]  rank_mg_6,
   input  logic signed [EVAL_WIDTH-1:0]  rank_mg_7,
   input  logic signed [EVAL_WIDTH-1:0]  rank_eg_0,
   input  logic signed [EVAL_WIDTH-1:0]  rank_eg_1,
   input  logic signed [EVAL_WIDTH-1:0]  rank_eg_2,
   input  logic signed [EVAL_WIDTH-1:0]  rank_eg_3,
   input  logic signed [EVAL_WIDTH-1:0]  rank_eg_4,
   input  logic signed [EVAL_WIDTH-1:0]  rank_eg_5,
   input  logic signed [EVAL_WIDTH-1:0]  rank_eg_6,
   input  logic signed [EVAL_WIDTH-1:0]  rank_eg_7,
   input  logic [eval_pkg::PHASE_W-1:0]  rank_phase_0,
   input  logic [eval_pkg::PHASE_W-1:0]  rank_phase_1,
   input  logic [eval_pkg::PHASE_W-1:0]  rank_phase_2,
   input  logic [eval_pkg::PHASE_W-1:0]  rank_phase_3,
   input  logic [eval_pkg::PHASE_W-1:0]  rank_phase_4,
   input  logic [eval_pkg::PHASE_W-1:0]  rank_phase_5,
   input  logic [eval_pkg::PHASE_W-1:0]  rank_phase_6,
   input  logic [eval_pkg::PHASE_W-1:0]  rank_phase_7,
   input  logic                          out_ready,
   output logic                          advance,
   output logic                          out_valid,
   output logic signed [EVAL_WIDTH-1:0]  eval,
   output logic [TAG_WIDTH-1:0]          out_tag
);

   localparam int SUM_W    = EVAL_WIDTH + $clog2(eval_pkg::RANKS);
   localparam int WEIGHT_W = $clog2(eval_pkg::PHASE_MAX + 1) + 1;  // Signed 0..62
   localparam int PROD_W   = SUM_W + WEIGHT_W;
   localparam int T_W      = PROD_W + 1;
   localparam int SCALED_W = T_W + 17;

   localparam logic [WEIGHT_W-2:0]       PHASE_LVL_MAX = (WEIGHT_W-1)'(eval_pkg::PHASE_MAX);
   localparam logic signed [16:0]        RECIP         = {1'b0, eval_pkg::BLEND_RECIP};
   localparam logic signed [SCALED_W-1:0] ROUND_BIAS   =
      SCALED_W'((1 << eval_pkg::BLEND_SHIFT) - 1);

   // Valid and tag line up with the rank evaluator outputs first
   logic                 rank_valid;
   logic                 s1_valid;
   logic                 s2_valid;
   logic [TAG_WIDTH-1:0] rank_tag;
   logic [TAG_WIDTH-1:0] s1_tag;
   logic [TAG_WIDTH-1:0] s2_tag;

   logic signed [SUM_W-1:0]      s1_mg;
   logic signed [SUM_W-1:0]      s1_eg;
   logic [eval_pkg::PHASE_W-1:0] s1_phase;
   logic signed [PROD_W-1:0]     s2_mg_prod;
   logic signed [PROD_W-1:0]     s2_eg_prod;

   logic [WEIGHT_W-2:0]          phase_lvl;
   logic signed [WEIGHT_W-1:0]   mg_weight;
   logic signed [WEIGHT_W-1:0]   eg_weight;
   logic signed [PROD_W-1:0]     mg_prod;
   logic signed [PROD_W-1:0]     eg_prod;
   logic signed [T_W-1:0]        t_sum;
   logic signed [SCALED_W-1:0]   scaled;
   logic signed [SCALED_W-1:0]   shifted;

   // Whole pipeline moves unless a result is waiting on the consumer
   assign advance = !out_valid || out_ready;

   // Stage 2 combinational part
   always_comb
   begin
      if (s1_phase > eval_pkg::PHASE_MAX)
         phase_lvl = PHASE_LVL_MAX;
      else
         phase_lvl = s1_phase[WEIGHT_W-2:0];
      mg_weight = {1'b0, phase_lvl};
      eg_weight = {1'b0, PHASE_LVL_MAX - phase_lvl};
      mg_prod   = s1_mg * mg_weight;
      eg_prod   = s1_eg * eg_weight;
   end

   // Stage 3 combinational part
   always_comb
   begin
      t_sum  = s2_mg_prod + s2_eg_prod;
      scaled = t_sum * RECIP;
      if (scaled < 0)
         scaled = scaled + ROUND_BIAS;  // Shift then truncates toward zero
      shifted = scaled >>> eval_pkg::BLEND_SHIFT;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rank_valid <= 1'b0;
         s1_valid   <= 1'b0;
         s2_valid   <= 1'b0;
         out_valid  <= 1'b0;
      end
      else if (advance)
      begin
         rank_valid <= board_valid_q;
         s1_valid   <= rank_valid;
         s2_valid   <= s1_valid;
         out_valid  <= s2_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         rank_tag <= tag_q;
         s1_tag   <= rank_tag;
         s2_tag   <= s1_tag;
         out_tag  <= s2_tag;

         s1_mg <= rank_mg_0 + rank_mg_1 + rank_mg_2 + rank_mg_3
                + rank_mg_4 + rank_mg_5 + rank_mg_6 + rank_mg_7;
         s1_eg <= rank_eg_0 + rank_eg_1 + rank_eg_2 + rank_eg_3
                + rank_eg_4 + rank_eg_5 + rank_eg_6 + rank_eg_7;
         s1_phase <= rank_phase_0 + rank_phase_1 + rank_phase_2 + rank_phase_3
                   + rank_phase_4 + rank_phase_5 + rank_phase_6 + rank_phase_7;

         s2_mg_prod <= mg_prod;
         s2_eg_prod <= eg_prod;

         eval <= shifted[EVAL_WIDTH-1:0];
      end
   end

endmodule

`default_nettype wire

/* rank_eval.sv */
/* Material and phase scorer for the eight squares of one rank, one cycle
   White counts positive and black negative. No square-specific terms */
`default_nettype none

module rank_eval #(
   parameter int EVAL_WIDTH = 16
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          advance,
   input  logic [eval_pkg::RANK_W-1:0]   rank,
   output logic signed [EVAL_WIDTH-1:0]  rank_mg,
   output logic signed [EVAL_WIDTH-1:0]  rank_eg,
   output logic [eval_pkg::PHASE_W-1:0]  rank_phase
);

   localparam int SQ_PER_RANK = eval_pkg::SQUARES / eval_pkg::RANKS;

   eval_pkg::piece_t             square [SQ_PER_RANK];
   logic signed [EVAL_WIDTH-1:0] mg_term [SQ_PER_RANK];
   logic signed [EVAL_WIDTH-1:0] eg_term [SQ_PER_RANK];
   logic [eval_pkg::PHASE_W-1:0] phase_term [SQ_PER_RANK];

   logic signed [EVAL_WIDTH-1:0] mg_sum;
   logic signed [EVAL_WIDTH-1:0] eg_sum;
   logic [eval_pkg::PHASE_W-1:0] phase_sum;

   always_comb
   begin
      mg_sum    = '0;
      eg_sum    = '0;
      phase_sum = '0;
      for (int i = 0; i < SQ_PER_RANK; i++)
      begin
         square[i].code = rank[i*eval_pkg::PIECE_W +: eval_pkg::PIECE_W];

         // Table lookups by kind with colour applied below
         mg_term[i]    = EVAL_WIDTH'(eval_pkg::MG_VALUE[square[i].f.kind]);
         eg_term[i]    = EVAL_WIDTH'(eval_pkg::EG_VALUE[square[i].f.kind]);
         phase_term[i] =
            (eval_pkg::PHASE_W)'(eval_pkg::PHASE_VALUE[square[i].f.kind]);

         if (square[i].f.black)
         begin
            mg_sum = mg_sum - mg_term[i];
            eg_sum = eg_sum - eg_term[i];
         end
         else
         begin
            mg_sum = mg_sum + mg_term[i];
            eg_sum = eg_sum + eg_term[i];
         end

         phase_sum = phase_sum + phase_term[i];  // Both colours add to phase
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rank_mg    <= '0;
         rank_eg    <= '0;
         rank_phase <= '0;
      end
      else if (advance)
      begin
         rank_mg    <= mg_sum;
         rank_eg    <= eg_sum;
         rank_phase <= phase_sum;
      end
   end

endmodule

`default_nettype wire

/* board_latch.sv */
/* Input register for board and tag. Loads only while the pipeline advances
   so a stalled board stays in front of the rank evaluators */
`default_nettype none

module board_latch #(
   parameter int TAG_WIDTH = 8
) (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         in_valid,
   input  logic                         in_ready,  // Pipeline advance
   input  logic [eval_pkg::BOARD_W-1:0] board,
   input  logic [TAG_WIDTH-1:0]         in_tag,
   output logic [eval_pkg::BOARD_W-1:0] board_q,
   output logic [TAG_WIDTH-1:0]         tag_q,
   output logic                         board_valid_q
);

   // A cycle without in_valid enters the pipeline as a bubble
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         board_valid_q <= 1'b0;
      else if (in_ready)
         board_valid_q <= in_valid;
   end

   always_ff @(posedge clk)
   begin
      if (in_ready)
      begin
         board_q <= board;
         tag_q   <= in_tag;   // Travels beside the board
      end
   end

endmodule

`default_nettype wire

/* eval_pkg.sv */
/* Square encoding, material and phase tables and blend constants
   Kind 7 is not a legal piece and scores as an empty square */
`default_nettype none

package eval_pkg;

   localparam int PIECE_W = 4;
   localparam int SQUARES = 64;
   localparam int RANKS   = 8;
   localparam int BOARD_W = SQUARES * PIECE_W;  // Square i at bits 4i+3:4i
   localparam int RANK_W  = BOARD_W / RANKS;    // Rank r is squares 8r to 8r+7

   // Piece kinds in the low three bits of a square
   localparam logic [2:0] KIND_EMPTY  = 3'd0;
   localparam logic [2:0] KIND_PAWN   = 3'd1;
   localparam logic [2:0] KIND_KNIGHT = 3'd2;
   localparam logic [2:0] KIND_BISHOP = 3'd3;
   localparam logic [2:0] KIND_ROOK   = 3'd4;
   localparam logic [2:0] KIND_QUEEN  = 3'd5;
   localparam logic [2:0] KIND_KING   = 3'd6;
   localparam logic [2:0] KIND_UNUSED = 3'd7;

   // One square word seen as a flat code or as colour over kind
   typedef union packed {
      logic [PIECE_W-1:0] code;
      struct packed {
         logic       black;  // Set for black pieces
         logic [2:0] kind;
      } f;
   } piece_t;

   localparam int VALUE_W = 11;  // Widest entry is the queen at 1025

   // Tables indexed by kind and listed from kind 7 down to kind 0
   localparam logic [7:0][VALUE_W-1:0] MG_VALUE = {
      11'd0,     // Unused
      11'd0,     // King
      11'd1025,  // Queen
      11'd477,   // Rook
      11'd365,   // Bishop
      11'd337,   // Knight
      11'd82,    // Pawn
      11'd0      // Empty
   };

   localparam logic [7:0][VALUE_W-1:0] EG_VALUE = {
      11'd0,
      11'd0,
      11'd936,
      11'd512,
      11'd297,
      11'd281,
      11'd94,
      11'd0
   };

   // Pawns and kings carry no phase weight
   localparam logic [7:0][3:0] PHASE_VALUE = {
      4'd0,
      4'd0,
      4'd9,
      4'd5,
      4'd3,
      4'd3,
      4'd0,
      4'd0
   };

   localparam int PHASE_MAX = 62;  // Phase of a full opening army set
   localparam int PHASE_W   = 11;

   // Division by 62 done as a multiply and a shift
   localparam logic [15:0] BLEND_RECIP = 16'd16912;  // Truncated 2^20 / 62
   localparam int          BLEND_SHIFT = 20;

endpackage

`default_nettype wire
